//--- compile.f
hdl/pcie_sym_pkg.sv
hdl/pcie_rx_pkg.sv
hdl/rx_frame_decode.sv
hdl/rx_byte_packer.sv
hdl/rx_beat_fifo.sv
hdl/pcie_rx_data_handler.sv
sim/tb_pcie_rx_data_handler.sv

//--- Bender.yml
package:
  name: pcie_rx_data_handler

sources:
  # packages first, then the datapath and the top level
  - files:
      - hdl/pcie_sym_pkg.sv
      - hdl/pcie_rx_pkg.sv
      - hdl/rx_frame_decode.sv
      - hdl/rx_byte_packer.sv
      - hdl/rx_beat_fifo.sv
      - hdl/pcie_rx_data_handler.sv
  - target: test
    files:
      - sim/tb_pcie_rx_data_handler.sv

//--- sim/tb_pcie_rx_data_handler.sv
`timescale 1ns/10ps

module tb_pcie_rx_data_handler
  import pcie_sym_pkg::*;
  import pcie_rx_pkg::*;
();

  logic   clk_i;
  logic   rst_i;
  logic   link_up;
  logic   fifo_empty;
  word_t  data;
  kflag_t data_k;
  logic   data_valid;
  logic   tready;
  logic   rd_en;
  word_t  tdata;
  keep_t  tkeep;
  logic   tlast;
  logic   tuser;
  logic   tvalid;
  beat_s  out_beat;

  // PHY FIFO model contents
  word_t  phy_data_q[$];
  kflag_t phy_k_q[$];
  // byte stream under construction and the beats it should give
  byte_t  stim_b[$];
  logic   stim_k[$];
  beat_s  exp_q[$];
  // tready pattern, used while rand_ready is set
  logic   ready_pat [1024];
  logic   rand_ready;
  int     cycle;
  int     words_total;
  int     errors;
  int     tests;
  int     rd_cnt;
  int     first_tv;
  int     dv_cyc[$];
  // beat offered without ready on the last edge
  logic   held;
  beat_s  held_beat;

  pcie_rx_data_handler #(
    .BEAT_FIFO_DEPTH (4)
  ) u_dut (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .phy_link_up_i    (link_up),
    .phy_fifo_empty_i (fifo_empty),
    .data_i           (data),
    .data_k_i         (data_k),
    .data_valid_i     (data_valid),
    .m_axis_tready_i  (tready),
    .phy_fifo_rd_en_o (rd_en),
    .m_axis_tdata_o   (tdata),
    .m_axis_tkeep_o   (tkeep),
    .m_axis_tlast_o   (tlast),
    .m_axis_tuser_o   (tuser),
    .m_axis_tvalid_o  (tvalid)
  );

  assign out_beat = {tdata, tkeep, tlast, tuser};

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle  <= cycle + 1;
    tready <= rand_ready ? ready_pat[cycle[9:0]] : 1'b1;
  end

  // PHY FIFO model, word comes back one cycle after the read
  always @(posedge clk_i) begin
    data_valid <= 1'b0;
    if (rd_en) begin
      if (phy_data_q.size() == 0) begin
        $display("read enable at %0t while the FIFO model was empty", $time);
        errors++;
      end else begin
        data       <= phy_data_q.pop_front();
        data_k     <= phy_k_q.pop_front();
        data_valid <= 1'b1;
      end
    end
    fifo_empty <= (phy_data_q.size() == 0);
  end

  function automatic word_t byte_mask(keep_t k);
    word_t m;
    for (int i = 0; i < WORD_BYTES; i++) m[8*i +: 8] = {8{k[i]}};
    return m;
  endfunction

  task automatic compare_value(string name, logic [31:0] got, logic [31:0] want);
    if (got !== want) begin
      $display("Error at %0t: %s got %h expected %h", $time, name, got, want);
      errors++;
    end
  endtask

  // output side checker, all values as seen by the DUT on this edge
  always @(posedge clk_i) begin : check_beats
    beat_s e;
    if (data_valid) dv_cyc.push_back(cycle);
    if (rd_en) rd_cnt++;
    if (rd_en && (!link_up || fifo_empty)) begin
      $display("read enable at %0t with the link down or the FIFO empty", $time);
      errors++;
    end
    if (tvalid && first_tv < 0) first_tv = cycle;
    if (held && (!tvalid || out_beat != held_beat)) begin
      $display("beat at %0t changed or was withdrawn before it transferred", $time);
      errors++;
    end
    held      = tvalid && !tready;
    held_beat = out_beat;
    if (tvalid && tready) begin
      if (exp_q.size() == 0) begin
        $display("unexpected beat at %0t with data %h", $time, tdata);
        errors++;
      end else begin
        e = exp_q.pop_front();
        // bytes outside tkeep carry no meaning
        compare_value("m_axis_tdata_o", tdata & byte_mask(e.keep), e.data & byte_mask(e.keep));
        compare_value("m_axis_tkeep_o", 32'(tkeep), 32'(e.keep));
        compare_value("m_axis_tlast_o", 32'(tlast), 32'(e.last));
        compare_value("m_axis_tuser_o", 32'(tuser), 32'(e.user));
      end
    end
  end

  // expected beats for the bytes now in stim_b and stim_k
  function automatic void pack_ref();
    byte_t pay[$];
    logic  in_pkt;
    logic  tlp;
    beat_s b;
    in_pkt = 1'b0;
    tlp    = 1'b0;
    foreach (stim_b[i]) begin
      if (!in_pkt && stim_k[i] && (stim_b[i] == SYM_STP || stim_b[i] == SYM_SDP)) begin
        in_pkt = 1'b1;
        tlp    = (stim_b[i] == SYM_STP);
        pay.delete();
      end else if (in_pkt && stim_k[i] && stim_b[i] == SYM_END) begin
        in_pkt = 1'b0;
        // cut payload into 4-byte beats, low bytes first
        for (int j = 0; j < pay.size(); j += WORD_BYTES) begin
          b = '0;
          for (int n = 0; n < WORD_BYTES && j + n < pay.size(); n++) begin
            b.data[8*n +: 8] = pay[j+n];
            b.keep[n]        = 1'b1;
          end
          b.last = (j + WORD_BYTES >= pay.size());
          b.user = tlp;
          exp_q.push_back(b);
        end
      end else if (in_pkt) begin
        pay.push_back(stim_b[i]);
      end
    end
  endfunction

  task automatic add_byte(byte_t b, logic k);
    stim_b.push_back(b);
    stim_k.push_back(k);
  endtask

  // start, len payload bytes, END
  task automatic add_packet(logic tlp, int len);
    add_byte(tlp ? SYM_STP : SYM_SDP, 1'b1);
    repeat (len) add_byte(byte_t'($urandom), 1'b0);
    add_byte(SYM_END, 1'b1);
  endtask

  // filler between packets: COM, SKP, IDL, logical idle, stray END
  task automatic add_idle(int n);
    int sel;
    repeat (n) begin
      sel = int'($urandom % 5);
      case (sel)
        0: add_byte(8'hBC, 1'b1);
        1: add_byte(8'h1C, 1'b1);
        2: add_byte(8'h7C, 1'b1);
        3: add_byte(8'h00, 1'b0);
        default: add_byte(SYM_END, 1'b1);
      endcase
    end
  endtask

  task automatic pad_word();
    while (stim_b.size() % WORD_BYTES != 0) add_byte(8'h7C, 1'b1);
  endtask

  // hand the stream to the reference and to the PHY FIFO model
  task automatic load_stream();
    word_t  w;
    kflag_t k;
    pad_word();
    @(negedge clk_i);
    pack_ref();
    for (int i = 0; i < stim_b.size(); i += WORD_BYTES) begin
      for (int n = 0; n < WORD_BYTES; n++) begin
        w[8*n +: 8] = stim_b[i+n];
        k[n]        = stim_k[i+n];
      end
      phy_data_q.push_back(w);
      phy_k_q.push_back(k);
    end
    words_total += stim_b.size() / WORD_BYTES;
    stim_b.delete();
    stim_k.delete();
  endtask

  task automatic finish_test(string name, int err0);
    while (exp_q.size() != 0) @(negedge clk_i);
    tests++;
    $display("test %0d, %s: %0d errors", tests, name, errors - err0);
  endtask

  initial begin
    int err0;
    int rd_base;
    void'($urandom(68131));
    rst_i      = 1'b1;
    link_up    = 1'b0;
    fifo_empty = 1'b1;
    data       = '0;
    data_k     = '0;
    data_valid = 1'b0;
    tready     = 1'b0;
    rand_ready = 1'b0;
    first_tv   = -1;
    foreach (ready_pat[i]) ready_pat[i] = ($urandom % 2) != 0;
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    err0 = errors;
    if (rd_en !== 1'b0 || tvalid !== 1'b0) begin
      $display("read enable or tvalid not low after reset");
      errors++;
    end
    finish_test("reset state", err0);

    // aligned TLP, 14 bytes, 4 words
    err0 = errors;
    @(posedge clk_i);
    link_up <= 1'b1;
    add_packet(1'b1, 14);
    load_stream();
    dv_cyc.delete();
    first_tv = -1;
    while (first_tv < 0) @(negedge clk_i);
    // first beat is closed by the second payload byte of word 1
    if (first_tv != dv_cyc[1] + 3) begin
      $display("Error at %0t: m_axis_tvalid_o first cycle got %0d expected %0d",
               $time, first_tv, dv_cyc[1] + 3);
      errors++;
    end
    finish_test("single aligned TLP", err0);

    err0 = errors;
    for (int off = 1; off < WORD_BYTES; off++) begin
      for (int rem = 1; rem <= WORD_BYTES; rem++) begin
        add_idle(off);
        add_packet(1'b0, WORD_BYTES + rem);
        pad_word();
      end
    end
    load_stream();
    finish_test("DLLP offsets and remainders", err0);

    // END and next start share words 1 and 3
    err0 = errors;
    add_packet(1'b1, 5);
    add_packet(1'b0, 6);
    add_packet(1'b1, 3);
    add_idle(7);
    add_packet(1'b0, 2);
    add_idle(3);
    add_packet(1'b1, 9);
    load_stream();
    finish_test("back to back packets and idle bytes", err0);

    err0 = errors;
    rand_ready = 1'b1;
    repeat (30) begin
      add_idle(int'($urandom % 6));
      add_packet(1'($urandom % 2), 2 + int'($urandom % 23));
    end
    load_stream();
    finish_test("random tready, 30 packets", err0);
    rand_ready = 1'b0;

    // no reads with the link down, none with the FIFO model empty
    err0 = errors;
    @(posedge clk_i);
    link_up <= 1'b0;
    add_packet(1'b1, 6);
    load_stream();
    rd_base = rd_cnt;
    repeat (20) @(negedge clk_i);
    if (rd_cnt != rd_base) begin
      $display("read enable rose while the link was down");
      errors++;
    end
    @(posedge clk_i);
    link_up <= 1'b1;
    while (exp_q.size() != 0) @(negedge clk_i);
    rd_base = rd_cnt;
    repeat (20) @(negedge clk_i);
    if (rd_cnt != rd_base) begin
      $display("read enable rose while the FIFO model was empty");
      errors++;
    end
    finish_test("read enable gating", err0);

    // room for a stray beat to show up
    repeat (10) @(negedge clk_i);
    $display("tests: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // 40 cycles per queued word plus fixed slack
  initial begin : watchdog
    while (cycle <= 40 * words_total + 200) @(posedge clk_i);
    $display("timeout at cycle %0d, %0d beats still expected", cycle, exp_q.size());
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- hdl/pcie_rx_data_handler.sv
`timescale 1ns/10ps

module pcie_rx_data_handler
  import pcie_rx_pkg::*;
#(
  // output beat FIFO depth, at least 4
  parameter int BEAT_FIFO_DEPTH = 4
) (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   phy_link_up_i,
  input  logic   phy_fifo_empty_i,
  input  word_t  data_i,
  input  kflag_t data_k_i,
  input  logic   data_valid_i,
  input  logic   m_axis_tready_i,
  output logic   phy_fifo_rd_en_o,
  output word_t  m_axis_tdata_o,
  output keep_t  m_axis_tkeep_o,
  output logic   m_axis_tlast_o,
  output logic   m_axis_tuser_o,
  output logic   m_axis_tvalid_o
);

  // classified word, decode to packer
  sym_word_s sym;
  // packed beats, packer to FIFO, a is the older
  beat_s     beat_a;
  beat_s     beat_b;
  logic      beat_a_we;
  logic      beat_b_we;
  // FIFO can take one more word
  logic      room;

  // read control and framing
  rx_frame_decode u_decode (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .phy_link_up_i    (phy_link_up_i),
    .phy_fifo_empty_i (phy_fifo_empty_i),
    .room_i           (room),
    .data_i           (data_i),
    .data_k_i         (data_k_i),
    .data_valid_i     (data_valid_i),
    .phy_fifo_rd_en_o (phy_fifo_rd_en_o),
    .sym_o            (sym)
  );

  // payload bytes into 32-bit beats
  rx_byte_packer u_packer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .sym_i       (sym),
    .beat_a_o    (beat_a),
    .beat_b_o    (beat_b),
    .beat_a_we_o (beat_a_we),
    .beat_b_we_o (beat_b_we)
  );

  // absorbs tready back-pressure
  rx_beat_fifo #(
    .BEAT_FIFO_DEPTH (BEAT_FIFO_DEPTH)
  ) u_fifo (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .beat_a_i        (beat_a),
    .beat_b_i        (beat_b),
    .beat_a_we_i     (beat_a_we),
    .beat_b_we_i     (beat_b_we),
    .m_axis_tready_i (m_axis_tready_i),
    .room_o          (room),
    .m_axis_tdata_o  (m_axis_tdata_o),
    .m_axis_tkeep_o  (m_axis_tkeep_o),
    .m_axis_tlast_o  (m_axis_tlast_o),
    .m_axis_tuser_o  (m_axis_tuser_o),
    .m_axis_tvalid_o (m_axis_tvalid_o)
  );

endmodule

//--- hdl/rx_beat_fifo.sv
`timescale 1ns/10ps

module rx_beat_fifo
  import pcie_rx_pkg::*;
#(
  // at least 4, two writes per cycle plus one beat draining
  parameter int BEAT_FIFO_DEPTH = 4
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  beat_s beat_a_i,
  input  beat_s beat_b_i,
  input  logic  beat_a_we_i,
  input  logic  beat_b_we_i,
  input  logic  m_axis_tready_i,
  output logic  room_o,
  output word_t m_axis_tdata_o,
  output keep_t m_axis_tkeep_o,
  output logic  m_axis_tlast_o,
  output logic  m_axis_tuser_o,
  output logic  m_axis_tvalid_o
);

  typedef logic [$clog2(BEAT_FIFO_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(BEAT_FIFO_DEPTH+1)-1:0] cnt_t;

  // free entries needed to take one more word, which makes two beats
  localparam int RoomMin = 3;

  beat_s      mem_q [BEAT_FIFO_DEPTH];
  ptr_t       wr_ptr_q;
  ptr_t       rd_ptr_q;
  cnt_t       count_q;
  beat_s      wr_first;
  logic [1:0] n_wr;
  logic       rd;
  beat_s      head;

  // wrap for any depth, not only powers of two
  function automatic ptr_t ptr_next(ptr_t p);
    return (p == ptr_t'(BEAT_FIFO_DEPTH - 1)) ? '0 : p + ptr_t'(1);
  endfunction

  // lowest free slot gets the older beat
  assign wr_first = beat_a_we_i ? beat_a_i : beat_b_i;
  assign n_wr     = {1'b0, beat_a_we_i} + {1'b0, beat_b_we_i};
  assign rd       = m_axis_tvalid_o && m_axis_tready_i;

  always_ff @(posedge clk_i) begin
    if (n_wr != 2'd0) begin
      mem_q[wr_ptr_q] <= wr_first;
    end
    if (beat_a_we_i && beat_b_we_i) begin
      mem_q[ptr_next(wr_ptr_q)] <= beat_b_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (n_wr == 2'd2) begin
        wr_ptr_q <= ptr_next(ptr_next(wr_ptr_q));
      end else if (n_wr == 2'd1) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (rd) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      count_q <= count_q + cnt_t'(n_wr) - cnt_t'(rd);
    end
  end

  // fall-through, head is shown as soon as it is counted
  assign head            = mem_q[rd_ptr_q];
  assign m_axis_tvalid_o = (count_q != '0);
  assign m_axis_tdata_o  = head.data;
  assign m_axis_tkeep_o  = head.keep;
  assign m_axis_tlast_o  = head.last;
  assign m_axis_tuser_o  = head.user;

  assign room_o = (BEAT_FIFO_DEPTH - int'(count_q)) >= RoomMin;

endmodule

//--- hdl/rx_byte_packer.sv
`timescale 1ns/10ps

module rx_byte_packer
  import pcie_sym_pkg::*;
  import pcie_rx_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  sym_word_s sym_i,
  output beat_s     beat_a_o,
  output beat_s     beat_b_o,
  output logic      beat_a_we_o,
  output logic      beat_b_we_o
);

  // fill level of the holding buffer, 0 to WORD_BYTES
  typedef logic [$clog2(WORD_BYTES+1)-1:0] fill_t;

  // holding buffer
  // a full word waits here until the next byte shows
  // whether it closes the packet, so tlast is never late
  word_t       hold_q;
  word_t       hold_n;
  fill_t       fill_q;
  fill_t       fill_n;
  // type of the open packet
  logic        user_q;
  logic        user_n;
  // a start was seen and no END yet
  logic        open_q;
  logic        open_n;

  // beats formed from the current word, oldest first
  beat_s       beat_n [2];
  logic [1:0]  nbeat_n;

  beat_s       beat_a_q;
  beat_s       beat_b_q;
  logic        beat_a_we_q;
  logic        beat_b_we_q;

  // keep mask for a fill of 1 to WORD_BYTES
  function automatic keep_t keep_from_fill(fill_t f);
    return keep_t'((1 << f) - 1);
  endfunction

  function automatic beat_s make_beat(word_t d, fill_t f, logic last, logic user);
    beat_s b;
    b.data = d;
    b.keep = keep_from_fill(f);
    b.last = last;
    b.user = user;
    return b;
  endfunction

  always_comb begin : pack_word
    byte_t b;
    hold_n    = hold_q;
    fill_n    = fill_q;
    user_n    = user_q;
    open_n    = open_q;
    beat_n[0] = '0;
    beat_n[1] = '0;
    nbeat_n   = '0;
    if (sym_i.valid) begin
      for (int i = 0; i < WORD_BYTES; i++) begin
        b = sym_i.data[8*i +: 8];
        case (sym_i.cls[i])
          SYM_START_TLP, SYM_START_DLLP: begin
            // new packet, latch its type
            open_n = 1'b1;
            user_n = (sym_i.cls[i] == SYM_START_TLP);
            fill_n = '0;
            hold_n = '0;
          end
          SYM_PKT_END: begin
            // remainder goes out with tlast
            // an empty packet has nothing to send
            if (open_n && fill_n != '0) begin
              beat_n[nbeat_n[0]] = make_beat(hold_n, fill_n, 1'b1, user_n);
              nbeat_n            = nbeat_n + 2'd1;
            end
            open_n = 1'b0;
            fill_n = '0;
            hold_n = '0;
          end
          default: begin
            if (open_n) begin
              // more payload, so a full buffer is not the last beat
              if (fill_n == fill_t'(WORD_BYTES)) begin
                beat_n[nbeat_n[0]] = make_beat(hold_n, fill_n, 1'b0, user_n);
                nbeat_n            = nbeat_n + 2'd1;
                fill_n             = '0;
                hold_n             = '0;
              end
              hold_n[8*fill_n +: 8] = b;
              fill_n                = fill_n + fill_t'(1);
            end
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hold_q      <= '0;
      fill_q      <= '0;
      user_q      <= 1'b0;
      open_q      <= 1'b0;
      beat_a_we_q <= 1'b0;
      beat_b_we_q <= 1'b0;
    end else begin
      hold_q      <= hold_n;
      fill_q      <= fill_n;
      user_q      <= user_n;
      open_q      <= open_n;
      // b only ever follows a
      beat_a_we_q <= (nbeat_n != 2'd0);
      beat_b_we_q <= (nbeat_n == 2'd2);
    end
  end

  // beat payload, qualified by the write strobes
  always_ff @(posedge clk_i) begin
    beat_a_q <= beat_n[0];
    beat_b_q <= beat_n[1];
  end

  assign beat_a_o    = beat_a_q;
  assign beat_b_o    = beat_b_q;
  assign beat_a_we_o = beat_a_we_q;
  assign beat_b_we_o = beat_b_we_q;

endmodule

//--- hdl/rx_frame_decode.sv
`timescale 1ns/10ps

module rx_frame_decode
  import pcie_sym_pkg::*;
  import pcie_rx_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      phy_link_up_i,
  input  logic      phy_fifo_empty_i,
  input  logic      room_i,
  input  word_t     data_i,
  input  kflag_t    data_k_i,
  input  logic      data_valid_i,
  output logic      phy_fifo_rd_en_o,
  output sym_word_s sym_o
);

  // packet framing state at a byte boundary
  typedef enum logic {
    ST_IDLE,
    ST_IN_PKT
  } pkt_state_e;

  // reads issued and not yet counted in the beat FIFO
  // rd_en, data_valid, decode reg, packer reg
  localparam int InFlight = 3;

  pkt_state_e                 state_q;
  pkt_state_e                 state_n;
  sym_class_e [WORD_BYTES-1:0] cls_n;
  logic [InFlight-1:0]        rd_hist_q;
  logic                       rd_busy;
  sym_word_s                  sym_q;

  // raw class from the K flag and the byte value
  function automatic sym_class_e byte_class(byte_t b, logic is_k);
    sym_class_e c;
    c = SYM_DATA;
    if (is_k) begin
      case (b)
        SYM_STP: c = SYM_START_TLP;
        SYM_SDP: c = SYM_START_DLLP;
        SYM_END: c = SYM_PKT_END;
        // COM, SKP and the like
        default: c = SYM_DATA;
      endcase
    end
    return c;
  endfunction

  // room_i only covers the two beats of a single word
  // so hold off while an earlier read is still on its way
  assign rd_busy = |rd_hist_q;

  assign phy_fifo_rd_en_o = phy_link_up_i && !phy_fifo_empty_i && room_i && !rd_busy;

  // walk the word in time order, byte 0 first
  always_comb begin : classify_word
    pkt_state_e st;
    sym_class_e raw;
    st = state_q;
    for (int i = 0; i < WORD_BYTES; i++) begin
      raw      = byte_class(data_i[8*i +: 8], data_k_i[i]);
      // default is plain data, packer drops it outside a packet
      cls_n[i] = SYM_DATA;
      case (st)
        ST_IDLE: begin
          // only a start leaves idle, a stray END is dropped
          if (raw == SYM_START_TLP || raw == SYM_START_DLLP) begin
            cls_n[i] = raw;
            st       = ST_IN_PKT;
          end
        end
        default: begin
          // inside a packet only END is framing
          if (raw == SYM_PKT_END) begin
            cls_n[i] = SYM_PKT_END;
            st       = ST_IDLE;
          end
        end
      endcase
    end
    state_n = st;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= ST_IDLE;
      rd_hist_q   <= '0;
      sym_q.valid <= 1'b0;
    end else begin
      rd_hist_q   <= {rd_hist_q[InFlight-2:0], phy_fifo_rd_en_o};
      sym_q.valid <= data_valid_i;
      // framing state only moves on a real word
      if (data_valid_i) begin
        state_q <= state_n;
      end
    end
  end

  // payload side, qualified by sym_q.valid
  always_ff @(posedge clk_i) begin
    sym_q.cls  <= cls_n;
    sym_q.data <= data_i;
  end

  assign sym_o = sym_q;

endmodule

//--- hdl/pcie_rx_pkg.sv
package pcie_rx_pkg;

  import pcie_sym_pkg::*;

  // one lane, 32-bit PIPE word at gen1/gen2
  localparam int WORD_BYTES = 4;

  // one symbol after 8b/10b decode
  typedef logic [7:0] byte_t;

  // one PIPE word, byte 0 in bits 7:0 and first in time
  typedef logic [8*WORD_BYTES-1:0] word_t;

  // byte enables of an output beat, low bytes first
  typedef logic [WORD_BYTES-1:0] keep_t;

  // K flags of a PIPE word, one per byte
  typedef logic [WORD_BYTES-1:0] kflag_t;

  // word after classification in rx_frame_decode
  // cls[i] belongs to data[8*i +: 8]
  typedef struct packed {
    logic                        valid;
    sym_class_e [WORD_BYTES-1:0] cls;
    word_t                       data;
  } sym_word_s;

  // one AXI-Stream beat towards the data link layer
  typedef struct packed {
    // payload bytes, framing already removed
    word_t data;
    // contiguous from bit 0
    keep_t keep;
    // final beat of the packet
    logic  last;
    // 1 for a TLP, 0 for a DLLP
    logic  user;
  } beat_s;

endpackage

//--- hdl/pcie_sym_pkg.sv
package pcie_sym_pkg;

  // framing K-codes of the 8b/10b rates, gen1 and gen2 only
  // gen3+ uses tokens in 128b/130b blocks, not handled here

  // K27.7, opens a TLP
  localparam logic [7:0] SYM_STP = 8'hFB;

  // K28.2, opens a DLLP
  localparam logic [7:0] SYM_SDP = 8'h5C;

  // K29.7, closes a good TLP or DLLP
  localparam logic [7:0] SYM_END = 8'hFD;

  // byte class as seen by the packer
  // any other K symbol (COM, SKP, IDL ...) is classed as data
  // and decode drops it when it falls outside a packet
  typedef enum logic [1:0] {
    // payload byte, or filler outside a packet
    SYM_DATA,
    // STP, packet is a TLP
    SYM_START_TLP,
    // SDP, packet is a DLLP
    SYM_START_DLLP,
    // END of the open packet
    SYM_PKT_END
  } sym_class_e;

endpackage
